//--- design/rank_defs.svh
// fixed sizes; RANK_TAG_W must hold RANK_LANES-1 and RANK_PASSES must be at least RANK_LANES
`ifndef RANK_DEFS_SVH
`define RANK_DEFS_SVH

// lanes per item
`define RANK_LANES 9

// value, scalar and product width
`define RANK_DATA_W 8

// origin lane tag width
`define RANK_TAG_W 4

// sorted position that gets scaled
`define RANK_SEL 1

// odd-even transposition passes
`define RANK_PASSES 9

`endif

//--- design/rank_pkg.sv
// lane and tag types for the nine-lane sort; tagged_lane_t packs the value above the tag
`default_nettype none

`include "rank_defs.svh"

package rank_pkg;

    // one data value
    typedef logic [`RANK_DATA_W-1:0] lane_t;

    // lane number an item value entered on
    typedef logic [`RANK_TAG_W-1:0] tag_t;

    // value plus its origin, carried through the sort
    typedef struct packed {
        lane_t value;
        tag_t  tag;
    } tagged_lane_t;

    // lane 0 sits in the low byte
    typedef lane_t [`RANK_LANES-1:0] lane_vec_t;

endpackage

`default_nettype wire

//--- design/rank_scale_top.sv
// no back-pressure: an item taken on edge N shows for one cycle after edge N+10
`timescale 1ns/1ps
`default_nettype none

module rank_scale_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  rank_pkg::lane_t     scalar,
    input  rank_pkg::lane_vec_t in_lanes,
    output logic                out_valid,
    output rank_pkg::lane_vec_t out_lanes,
    output rank_pkg::lane_t     product
);

    // sorted items, network to scaler
    sort_bus_if sorted_bus ();

    // nine passes, 9 cycles
    sort_network u_net (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_lanes (in_lanes),
        .scalar   (scalar),
        .sorted   (sorted_bus)
    );

    // multiply and scatter, 1 cycle
    scale_scatter u_scale (
        .clk       (clk),
        .rst_n     (rst_n),
        .sorted    (sorted_bus),
        .out_valid (out_valid),
        .out_lanes (out_lanes),
        .product   (product)
    );

endmodule

`default_nettype wire

//--- design/scale_scatter.sv
// latency 1; product is modulo 256 and outputs read zero whenever out_valid is low
`timescale 1ns/1ps
`default_nettype none

`include "rank_defs.svh"

module scale_scatter (
    input logic                 clk,
    input logic                 rst_n,
    sort_bus_if.dst             sorted,
    output logic                out_valid,
    output rank_pkg::lane_vec_t out_lanes,
    output rank_pkg::lane_t     product
);

    import rank_pkg::*;

    tagged_lane_t            sel;
    lane_t                   mul_res;
    lane_vec_t               scatter;
    logic [`RANK_LANES-1:0]  lane_nz;

    // shift-and-add, high bits fall off the top
    function automatic lane_t shift_add_mul(input lane_t mcand_in, input lane_t mplier_in);
        lane_t acc;
        lane_t mcand;
        lane_t mplier;
        acc    = '0;
        mcand  = mcand_in;
        mplier = mplier_in;
        for (int k = 0; k < `RANK_DATA_W; k++)
        begin
            if (mplier[0])
            begin
                acc = acc + mcand;
            end
            mcand  = mcand << 1;
            mplier = mplier >> 1;
        end
        return acc;
    endfunction

    assign sel     = sorted.lanes[`RANK_SEL];
    assign mul_res = shift_add_mul(sel.value, sorted.scale);

    // product goes back to the lane its value entered on
    always_comb
    begin
        for (int i = 0; i < `RANK_LANES; i++)
        begin
            scatter[i] = (sel.tag == tag_t'(i)) ? mul_res : '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            out_lanes <= '0;
            product   <= '0;
        end
        else
        begin
            out_valid <= sorted.valid;
            out_lanes <= sorted.valid ? scatter : '0;
            product   <= sorted.valid ? mul_res : '0;
        end
    end

    always_comb
    begin
        for (int i = 0; i < `RANK_LANES; i++)
        begin
            lane_nz[i] = |out_lanes[i];
        end
    end

    // a nonzero product must land in exactly one lane
    a_one_hot_out: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> ($countones(lane_nz) == ((product != '0) ? 1 : 0))
    );

endmodule

`default_nettype wire

//--- design/sort_bus_if.sv
// one item per cycle, no handshake; lanes and scale mean nothing while valid is low
`timescale 1ns/1ps
`default_nettype none

`include "rank_defs.svh"

interface sort_bus_if;

    import rank_pkg::*;

    logic                              valid;
    tagged_lane_t [`RANK_LANES-1:0]    lanes;
    // scalar rides along with its item
    lane_t                             scale;

    // producer side
    modport src (
        output valid,
        output lanes,
        output scale
    );

    // consumer side, sampled every rising clk
    modport dst (
        input valid,
        input lanes,
        input scale
    );

endinterface

`default_nettype wire

//--- design/sort_network.sv
// fixed RANK_PASSES-cycle latency, one item per cycle, ties sorted by origin lane
`timescale 1ns/1ps
`default_nettype none

`include "rank_defs.svh"

module sort_network (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input rank_pkg::lane_vec_t in_lanes,
    input rank_pkg::lane_t   scalar,
    sort_bus_if.src          sorted
);

    import rank_pkg::*;

    tagged_lane_t [`RANK_LANES-1:0] first_lanes;

    // bus 0 is the tagged input, bus k is the result of pass k-1
    sort_bus_if stage_bus [`RANK_PASSES] ();

    // tag each lane with the lane it entered on
    always_comb
    begin
        for (int i = 0; i < `RANK_LANES; i++)
        begin
            first_lanes[i].value = in_lanes[i];
            first_lanes[i].tag   = tag_t'(i);
        end
    end

    assign stage_bus[0].valid = in_valid;
    assign stage_bus[0].lanes = first_lanes;
    assign stage_bus[0].scale = scalar;

    // passes alternate even and odd, starting even
    generate
        for (genvar p = 0; p < `RANK_PASSES - 1; p++)
        begin : g_pass
            sort_stage #(
                .odd_phase (p % 2)
            ) u_pass (
                .clk   (clk),
                .rst_n (rst_n),
                .up    (stage_bus[p]),
                .down  (stage_bus[p+1])
            );
        end
    endgenerate

    // last pass drives the network output
    sort_stage #(
        .odd_phase ((`RANK_PASSES - 1) % 2)
    ) u_pass_last (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (stage_bus[`RANK_PASSES-1]),
        .down  (sorted)
    );

endmodule

`default_nettype wire

//--- design/sort_stage.sv
// one registered pass, latency 1; swaps only on strictly greater so ties keep lane order
`timescale 1ns/1ps
`default_nettype none

`include "rank_defs.svh"

module sort_stage #(
    parameter int odd_phase = 0
) (
    input logic     clk,
    input logic     rst_n,
    sort_bus_if.dst up,
    sort_bus_if.src down
);

    import rank_pkg::*;

    tagged_lane_t [`RANK_LANES-1:0] next_lanes;

    // compare-exchange on adjacent pairs of this phase
    always_comb
    begin
        next_lanes = up.lanes;
        for (int i = odd_phase; i + 1 < `RANK_LANES; i += 2)
        begin
            if (up.lanes[i].value > up.lanes[i+1].value)
            begin
                next_lanes[i]   = up.lanes[i+1];
                next_lanes[i+1] = up.lanes[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            down.valid <= 1'b0;
        end
        else
        begin
            down.valid <= up.valid;
        end
    end

    // lanes and scale, qualified by valid
    always_ff @(posedge clk)
    begin
        down.lanes <= next_lanes;
        down.scale <= up.scale;
    end

    // every pair this pass touched leaves it in order, equal values still in lane order
    generate
        for (genvar g = odd_phase; g + 1 < `RANK_LANES; g += 2)
        begin : g_pair_chk
            a_pair_ordered: assert property (
                @(posedge clk) disable iff (!rst_n)
                down.valid |-> (down.lanes[g].value < down.lanes[g+1].value
                    || (down.lanes[g].value == down.lanes[g+1].value
                        && down.lanes[g].tag < down.lanes[g+1].tag))
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- tb/rank_scale_vectors.svh
// named items, values listed lane 0 first; included inside rank_scale_tb after add_item
`ifndef RANK_SCALE_VECTORS_SVH
`define RANK_SCALE_VECTORS_SVH

task automatic load_vectors();
    // distinct values
    add_item("distinct_asc",
             '{8'd10, 8'd20, 8'd30, 8'd40, 8'd50, 8'd60, 8'd70, 8'd80, 8'd90}, 8'd3);
    add_item("distinct_desc",
             '{8'd90, 8'd80, 8'd70, 8'd60, 8'd50, 8'd40, 8'd30, 8'd20, 8'd10}, 8'd2);
    add_item("distinct_mixed",
             '{8'd55, 8'd3, 8'd200, 8'd17, 8'd99, 8'd8, 8'd140, 8'd61, 8'd33}, 8'd5);
    add_item("second_in_last_lane",
             '{8'd44, 8'd91, 8'd12, 8'd73, 8'd66, 8'd150, 8'd39, 8'd120, 8'd13}, 8'd7);

    // ties, lower origin lane ranks first
    add_item("tie_smallest_pair",
             '{8'd7, 8'd40, 8'd7, 8'd50, 8'd60, 8'd70, 8'd80, 8'd90, 8'd100}, 8'd4);
    add_item("tie_second_value",
             '{8'd30, 8'd9, 8'd1, 8'd9, 8'd9, 8'd70, 8'd80, 8'd90, 8'd100}, 8'd6);
    add_item("tie_far_apart",
             '{8'd200, 8'd150, 8'd25, 8'd180, 8'd160, 8'd170, 8'd190, 8'd25, 8'd25}, 8'd3);
    add_item("all_equal",
             '{8'd77, 8'd77, 8'd77, 8'd77, 8'd77, 8'd77, 8'd77, 8'd77, 8'd77}, 8'd3);

    // truncation to 8 bits
    add_item("large_times_large",
             '{8'd255, 8'd250, 8'd253, 8'd251, 8'd254, 8'd252, 8'd249, 8'd248, 8'd247}, 8'd255);
    add_item("all_max",
             '{8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255}, 8'd255);
    add_item("overflow_by_one",
             '{8'd128, 8'd129, 8'd130, 8'd131, 8'd132, 8'd133, 8'd134, 8'd135, 8'd136}, 8'd2);

    // zero products
    add_item("scalar_zero",
             '{8'd5, 8'd61, 8'd2, 8'd99, 8'd14, 8'd200, 8'd31, 8'd77, 8'd150}, 8'd0);
    add_item("all_zero_values",
             '{8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0}, 8'd9);
    add_item("power_of_two_wrap",
             '{8'd64, 8'd32, 8'd16, 8'd240, 8'd224, 8'd208, 8'd192, 8'd176, 8'd160}, 8'd8);
endtask

`endif

//--- tb/rank_scale_tb.sv
// self-checking; expects a fixed 10-cycle latency and no back-pressure, table items then LFSR items
`timescale 1ns/1ps
`default_nettype none

`include "rank_defs.svh"

module rank_scale_tb;

    import rank_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;
    localparam int LATENCY     = 10;
    localparam int LFSR_ITEMS  = 12;

    typedef logic [`RANK_DATA_W-1:0] vals_t [`RANK_LANES];

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    lane_t     scalar;
    lane_vec_t in_lanes;
    logic      out_valid;
    lane_vec_t out_lanes;
    lane_t     product;

    // stimulus items
    string     item_name [$];
    lane_vec_t item_lanes [$];
    lane_t     item_scale [$];

    // expectations in flight
    string     exp_name [$];
    lane_vec_t exp_lanes [$];
    lane_t     exp_product [$];
    int        exp_cycle [$];

    int          errors = 0;
    int          cycle_count = 0;
    logic        items_loaded = 1'b0;
    logic [15:0] lfsr = 16'd67;

    rank_scale_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .scalar    (scalar),
        .in_lanes  (in_lanes),
        .out_valid (out_valid),
        .out_lanes (out_lanes),
        .product   (product)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    task automatic add_item(input string name, input vals_t vals, input lane_t s);
        lane_vec_t packed_vals;
        for (int i = 0; i < `RANK_LANES; i++)
        begin
            packed_vals[i] = vals[i];
        end
        item_name.push_back(name);
        item_lanes.push_back(packed_vals);
        item_scale.push_back(s);
    endtask

    `include "rank_scale_vectors.svh"

    // taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int nbits, output lane_t val);
        val = '0;
        for (int b = 0; b < nbits; b++)
        begin
            lfsr = lfsr_step(lfsr);
            val  = {val[`RANK_DATA_W-2:0], lfsr[0]};
        end
    endtask

    // stable insertion sort of lane numbers, returns origin of the selected rank
    function automatic int origin_of_rank(input lane_vec_t v);
        int order [`RANK_LANES];
        int key;
        int j;
        for (int i = 0; i < `RANK_LANES; i++)
        begin
            order[i] = i;
        end
        for (int i = 1; i < `RANK_LANES; i++)
        begin
            key = order[i];
            j   = i - 1;
            while (j >= 0 && v[order[j]] > v[key])
            begin
                order[j+1] = order[j];
                j--;
            end
            order[j+1] = key;
        end
        return order[`RANK_SEL];
    endfunction

    task automatic queue_expected(input string name, input lane_vec_t v, input lane_t s,
                                  input int sample_cycle);
        int        origin;
        int        prod;
        lane_vec_t lanes;
        origin = origin_of_rank(v);
        prod   = (int'(v[origin]) * int'(s)) % 256;
        lanes  = '0;
        lanes[origin] = lane_t'(prod);
        exp_name.push_back(name);
        exp_lanes.push_back(lanes);
        exp_product.push_back(lane_t'(prod));
        exp_cycle.push_back(sample_cycle);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (out_valid === 1'b1)
        begin
            if (exp_name.size() == 0)
            begin
                $display("out_valid went high with no item pending at cycle %0d", cycle_count);
                errors++;
            end
            else
            begin
                if (product !== exp_product[0])
                begin
                    $display("error %s: product expected %0d actual %0d",
                             exp_name[0], exp_product[0], product);
                    errors++;
                end
                if (out_lanes !== exp_lanes[0])
                begin
                    $display("error %s: out_lanes expected %h actual %h",
                             exp_name[0], exp_lanes[0], out_lanes);
                    errors++;
                end
                // the next rising edge is the one that samples this output
                if (cycle_count + 1 != exp_cycle[0] + LATENCY)
                begin
                    $display("error %s: latency expected %0d actual %0d",
                             exp_name[0], LATENCY, cycle_count + 1 - exp_cycle[0]);
                    errors++;
                end
                void'(exp_name.pop_front());
                void'(exp_lanes.pop_front());
                void'(exp_product.pop_front());
                void'(exp_cycle.pop_front());
            end
        end
        else if (out_valid === 1'b0)
        begin
            if (out_lanes !== '0)
            begin
                $display("error idle: out_lanes expected 0 actual %h", out_lanes);
                errors++;
            end
            if (product !== '0)
            begin
                $display("error idle: product expected 0 actual %0d", product);
                errors++;
            end
        end
        else
        begin
            $display("out_valid is unknown at cycle %0d", cycle_count);
            errors++;
        end
    end

    initial
    begin
        lane_vec_t v;
        lane_t     s;
        lane_t     r;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        scalar   = '0;
        in_lanes = '0;

        load_vectors();
        // second half uses 3-bit values to force ties
        for (int k = 0; k < LFSR_ITEMS; k++)
        begin
            for (int i = 0; i < `RANK_LANES; i++)
            begin
                draw_bits((k < LFSR_ITEMS / 2) ? 8 : 3, r);
                v[i] = r;
            end
            draw_bits(8, s);
            item_name.push_back($sformatf("lfsr_%0d", k));
            item_lanes.push_back(v);
            item_scale.push_back(s);
        end
        items_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        // back to back, one item per cycle
        for (int n = 0; n < item_name.size(); n++)
        begin
            in_valid = 1'b1;
            in_lanes = item_lanes[n];
            scalar   = item_scale[n];
            queue_expected(item_name[n], item_lanes[n], item_scale[n], cycle_count + 1);
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_lanes = '0;
        scalar   = '0;

        while (exp_name.size() > 0)
        begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);

        $display("errors: %0d", errors);
        if (errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // run length follows the number of items
    initial
    begin
        int limit_ns;
        wait (items_loaded === 1'b1);
        limit_ns = (item_name.size() + LATENCY + RESET_CYCLES + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout: outputs missing, %0d items still pending", exp_name.size());
        $display("errors: %0d", errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
+incdir+tb
design/rank_pkg.sv
design/sort_bus_if.sv
design/sort_stage.sv
design/sort_network.sv
design/scale_scatter.sv
design/rank_scale_top.sv
tb/rank_scale_tb.sv
